/* include/mem_stage_defs.svh */
`ifndef MEM_STAGE_DEFS_SVH
`define MEM_STAGE_DEFS_SVH

// datapath widths
`define WORD_W        32          // data and address word
`define REG_ADDR_W    5           // gpr number

// L1 data cache geometry, 2 ways x 256 sets x 16 bytes
`define INDEX_W       8           // set index
`define OFFSET_W      2           // word within line
`define TAG_W         20          // 32 - 8 - 2 - 2
`define LINE_W        128         // four words per line
`define L2_ADDR_W     28          // line address, tag + index

// memory operations
// upper two bits give the class, lower two the size and signedness
`define MEM_OP_W      4
`define MEM_CLS_LOAD  2'b01
`define MEM_CLS_STORE 2'b10

`define MEM_OP_NOP    4'b0000
`define MEM_OP_LDW    4'b0100     // load word
`define MEM_OP_LDB    4'b0101     // load byte, sign extended
`define MEM_OP_LDBU   4'b0110     // load byte, zero extended
`define MEM_OP_STW    4'b1000     // store word
`define MEM_OP_STB    4'b1001     // store byte

`endif

/* verilog/mem_pkg.sv */
`include "mem_stage_defs.svh"

package mem_pkg;

    typedef logic [`WORD_W-1:0]     word_t;      // data word or byte address
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;  // gpr number
    typedef logic [`MEM_OP_W-1:0]   mem_op_t;    // class + size/sign

    typedef logic [`TAG_W-1:0]      tag_t;
    typedef logic [`INDEX_W-1:0]    index_t;
    typedef logic [`OFFSET_W-1:0]   offset_t;    // word select in a line
    typedef logic [`LINE_W-1:0]     line_t;
    typedef logic [`L2_ADDR_W-1:0]  l2_addr_t;   // {tag, index}

    // miss handling in dcache_ctrl
    typedef enum logic [1:0] {
        DC_IDLE,                                 // lookup, hits served here
        DC_WB,                                   // dirty victim out to L2
        DC_FILL                                  // line in from L2
    } dc_state_t;

endpackage

/* verilog/mem_ctrl.sv */
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module mem_ctrl (
    input  logic             ex_en,
    input  mem_pkg::mem_op_t ex_mem_op,
    input  mem_pkg::word_t   ex_mem_wr_data,  // store data from gpr
    input  mem_pkg::word_t   ex_out,          // alu result, address for ld/st
    input  mem_pkg::word_t   read_data_m,     // word at addr from the cache
    output mem_pkg::word_t   addr,
    output logic             access_mem,      // cache lookup request
    output logic             memwrite_m,
    output mem_pkg::word_t   wr_data,         // full word to write
    output mem_pkg::word_t   out,             // stage result
    output logic             miss_align
);
    import mem_pkg::*;

    logic       is_load;
    logic       is_store;
    logic       is_word;
    logic [1:0] lane;                         // byte lane in the word
    logic [7:0] rd_byte;
    word_t      merged_word;

    assign addr     = ex_out;
    assign lane     = ex_out[1:0];
    assign is_load  = ex_en && (ex_mem_op[`MEM_OP_W-1 -: 2] == `MEM_CLS_LOAD);
    assign is_store = ex_en && (ex_mem_op[`MEM_OP_W-1 -: 2] == `MEM_CLS_STORE);
    assign is_word  = (ex_mem_op == `MEM_OP_LDW) || (ex_mem_op == `MEM_OP_STW);

    // only word ops can be misaligned, bytes go anywhere
    assign miss_align = (is_load || is_store) && is_word && (lane != 2'b00);
    assign access_mem = (is_load || is_store) && !miss_align;
    assign memwrite_m = is_store && !miss_align;

    assign rd_byte = read_data_m[lane*8 +: 8];  // little endian lanes

    // byte store becomes read-modify-write of the cached word
    always_comb begin
        merged_word = read_data_m;
        merged_word[lane*8 +: 8] = ex_mem_wr_data[7:0];
    end

    assign wr_data = (ex_mem_op == `MEM_OP_STB) ? merged_word : ex_mem_wr_data;

    always_comb begin
        out = ex_out;                           // nop and stores pass alu result
        if (is_load && !miss_align) begin
            case (ex_mem_op)
                `MEM_OP_LDW:  out = read_data_m;
                `MEM_OP_LDB:  out = {{(`WORD_W-8){rd_byte[7]}}, rd_byte};
                `MEM_OP_LDBU: out = {{(`WORD_W-8){1'b0}}, rd_byte};
                default:      out = ex_out;
            endcase
        end
    end

endmodule

/* verilog/dcache_ctrl.sv */
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module dcache_ctrl (
    input  logic              clk,
    input  logic              arst_n,
    input  mem_pkg::word_t    addr,          // byte address
    input  logic              access_mem,
    input  logic              memwrite_m,
    input  mem_pkg::word_t    wr_data,       // store word, byte already merged
    output mem_pkg::word_t    read_data_m,
    output logic              miss_stall,    // level, holds the pipeline
    output mem_pkg::index_t   index,
    input  mem_pkg::tag_t     tag0_rd,
    input  mem_pkg::tag_t     tag1_rd,
    input  logic              valid0,
    input  logic              valid1,
    input  logic              dirty0,
    input  logic              dirty1,
    input  logic              lru,           // way to replace next
    input  mem_pkg::line_t    data0_rd,
    input  mem_pkg::line_t    data1_rd,
    output logic              block0_we,
    output logic              block1_we,
    output mem_pkg::tag_t     tag_wd,
    output mem_pkg::line_t    line_wd,
    output logic              dirty_wd,
    output logic              lru_we,
    output logic              lru_wd,
    output logic              drq,           // L2 request level
    output logic              l2_cache_rw,   // 1 = writeback
    output mem_pkg::l2_addr_t l2_addr,
    output mem_pkg::line_t    rd_to_l2,      // victim line
    input  logic              l2_rdy,        // one cycle pulse ends a transfer
    input  mem_pkg::line_t    data_wd_l2     // refill line, valid with l2_rdy
);
    import mem_pkg::*;

    dc_state_t state_q;
    dc_state_t state_n;
    tag_t      tag;
    tag_t      victim_tag;
    offset_t   offset;
    logic      hit0;
    logic      hit1;
    logic      hit;
    logic      hit_way;                       // 1 = way 1
    line_t     hit_line;
    line_t     merged_line;
    logic      victim_dirty;
    logic      xfer_done;
    logic      rdy_q;                         // l2_rdy seen last cycle
    logic      fill_we;
    logic      st_we;

    // address split, low 2 bits are the byte in word
    assign tag    = addr[`WORD_W-1 -: `TAG_W];
    assign index  = addr[`OFFSET_W+2 +: `INDEX_W];
    assign offset = addr[2 +: `OFFSET_W];

    assign hit0    = valid0 && (tag0_rd == tag);
    assign hit1    = valid1 && (tag1_rd == tag);
    assign hit     = hit0 || hit1;
    assign hit_way = hit1;

    assign hit_line    = hit_way ? data1_rd : data0_rd;
    assign read_data_m = hit_line[offset*`WORD_W +: `WORD_W];

    always_comb begin
        merged_line = hit_line;
        merged_line[offset*`WORD_W +: `WORD_W] = wr_data;
    end

    // victim is whatever lru points at, lru only moves on idle hits
    assign victim_tag   = lru ? tag1_rd : tag0_rd;
    assign victim_dirty = lru ? (valid1 && dirty1) : (valid0 && dirty0);
    assign rd_to_l2     = lru ? data1_rd : data0_rd;

    assign xfer_done = drq && l2_rdy;

    always_comb begin
        state_n = state_q;
        case (state_q)
            DC_IDLE: begin
                if (access_mem && !hit) begin
                    state_n = victim_dirty ? DC_WB : DC_FILL;
                end
            end
            DC_WB: begin
                if (xfer_done) begin
                    state_n = DC_FILL;
                end
            end
            DC_FILL: begin
                if (xfer_done) begin
                    state_n = DC_IDLE;            // replay lookup, now hits
                end
            end
            default: state_n = DC_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= DC_IDLE;
            rdy_q   <= 1'b0;
        end else begin
            state_q <= state_n;
            rdy_q   <= xfer_done;
        end
    end

    // rises in the presentation cycle, falls on the replay hit
    assign miss_stall = (state_q != DC_IDLE) || (access_mem && !hit);

    // drq drops for one cycle after each l2_rdy
    assign drq         = (state_q != DC_IDLE) && !rdy_q;
    assign l2_cache_rw = (state_q == DC_WB);
    assign l2_addr     = (state_q == DC_WB) ? {victim_tag, index} : {tag, index};

    assign fill_we = (state_q == DC_FILL) && xfer_done;
    assign st_we   = (state_q == DC_IDLE) && memwrite_m && hit;

    assign block0_we = fill_we ? !lru : (st_we && hit0);
    assign block1_we = fill_we ? lru  : (st_we && hit1);
    assign tag_wd    = tag;                   // same tag for fill and store hit
    assign line_wd   = fill_we ? data_wd_l2 : merged_line;
    assign dirty_wd  = !fill_we;              // refill clean, store dirty

    assign lru_we = (state_q == DC_IDLE) && access_mem && hit;
    assign lru_wd = !hit_way;                 // point at the other way

    a_one_way_we: assert property (@(posedge clk) disable iff (!arst_n)
        !(block0_we && block1_we));

    a_no_drq_idle: assert property (@(posedge clk) disable iff (!arst_n)
        (state_q == DC_IDLE) |-> !drq);

endmodule

/* verilog/l1_dcache_ram.sv */
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module l1_dcache_ram (
    input  logic            clk,
    input  logic            arst_n,
    input  mem_pkg::index_t index,
    input  logic            block0_we,
    input  logic            block1_we,
    input  mem_pkg::tag_t   tag_wd,
    input  mem_pkg::line_t  line_wd,
    input  logic            dirty_wd,
    input  logic            lru_we,
    input  logic            lru_wd,
    output mem_pkg::tag_t   tag0_rd,
    output mem_pkg::tag_t   tag1_rd,
    output logic            valid0,
    output logic            valid1,
    output logic            dirty0,
    output logic            dirty1,
    output logic            lru,
    output mem_pkg::line_t  data0_rd,
    output mem_pkg::line_t  data1_rd
);
    import mem_pkg::*;

    localparam int NSETS = 1 << `INDEX_W;

    logic [1:0]       way_we;
    tag_t             tag_rd_w   [2];
    line_t            data_rd_w  [2];
    logic [1:0]       valid_rd_w;
    logic [1:0]       dirty_rd_w;
    logic [NSETS-1:0] lru_q;                  // one bit per set

    assign way_we = {block1_we, block0_we};

    for (genvar w = 0; w < 2; w++) begin : g_way
        tag_t             tag_mem  [NSETS];
        line_t            data_mem [NSETS];
        logic [NSETS-1:0] valid_q;
        logic [NSETS-1:0] dirty_q;

        always_ff @(posedge clk) begin
            if (way_we[w]) begin
                tag_mem[index]  <= tag_wd;
                data_mem[index] <= line_wd;
            end
        end

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                valid_q <= '0;
                dirty_q <= '0;
            end else if (way_we[w]) begin
                valid_q[index] <= 1'b1;       // any way write installs the line
                dirty_q[index] <= dirty_wd;
            end
        end

        // async reads straight off the index
        assign tag_rd_w[w]   = tag_mem[index];
        assign data_rd_w[w]  = data_mem[index];
        assign valid_rd_w[w] = valid_q[index];
        assign dirty_rd_w[w] = dirty_q[index];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru_q <= '0;                      // way 0 replaced first
        end else if (lru_we) begin
            lru_q[index] <= lru_wd;
        end
    end

    assign tag0_rd  = tag_rd_w[0];
    assign tag1_rd  = tag_rd_w[1];
    assign data0_rd = data_rd_w[0];
    assign data1_rd = data_rd_w[1];
    assign valid0   = valid_rd_w[0];
    assign valid1   = valid_rd_w[1];
    assign dirty0   = dirty_rd_w[0];
    assign dirty1   = dirty_rd_w[1];
    assign lru      = lru_q[index];

endmodule

/* verilog/mem_reg.sv */
`timescale 1ns/1ps

module mem_reg (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               stall,
    input  logic               flush,
    input  logic               miss_stall,
    input  logic               ex_en,
    input  mem_pkg::reg_addr_t ex_dst_addr,
    input  logic               ex_gpr_we_n,
    input  mem_pkg::word_t     out,
    input  logic               miss_align,
    output logic               mem_en,
    output mem_pkg::reg_addr_t mem_dst_addr,
    output logic               mem_gpr_we_n,   // active low gpr write
    output mem_pkg::word_t     mem_out,
    output logic               mem_misalign
);

    logic do_load;                             // real instruction enters wb

    assign do_load = !flush && !stall && !miss_stall;

    // control fields, priority reset > flush > stall > miss > load
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_en       <= 1'b0;
            mem_gpr_we_n <= 1'b1;
            mem_misalign <= 1'b0;
        end else if (flush || (!stall && miss_stall)) begin
            mem_en       <= 1'b0;              // bubble
            mem_gpr_we_n <= 1'b1;
            mem_misalign <= 1'b0;
        end else if (do_load) begin
            mem_en       <= ex_en;
            mem_gpr_we_n <= miss_align ? 1'b1 : ex_gpr_we_n;  // no write on misalign
            mem_misalign <= miss_align;
        end
    end

    always_ff @(posedge clk) begin
        if (do_load) begin
            mem_dst_addr <= ex_dst_addr;
            mem_out      <= out;
        end
    end

    a_flush_bubble: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !mem_en);

endmodule

/* verilog/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               stall,
    input  logic               flush,
    input  logic               ex_en,
    input  mem_pkg::mem_op_t   ex_mem_op,
    input  mem_pkg::word_t     ex_mem_wr_data,
    input  mem_pkg::reg_addr_t ex_dst_addr,
    input  logic               ex_gpr_we_n,
    input  mem_pkg::word_t     ex_out,          // alu result or ld/st address
    output mem_pkg::word_t     fwd_data,        // bypass to EX
    output logic               miss_stall,
    output logic               drq,
    output logic               l2_cache_rw,
    output mem_pkg::l2_addr_t  l2_addr,
    output mem_pkg::line_t     rd_to_l2,
    input  logic               l2_rdy,
    input  mem_pkg::line_t     data_wd_l2,
    output logic               mem_en,
    output mem_pkg::reg_addr_t mem_dst_addr,
    output logic               mem_gpr_we_n,
    output mem_pkg::word_t     mem_out,
    output logic               mem_misalign
);
    import mem_pkg::*;

    word_t  addr;
    word_t  wr_data;
    word_t  read_data_m;
    word_t  out;
    logic   access_mem;
    logic   memwrite_m;
    logic   miss_align;
    index_t index;
    tag_t   tag0_rd;
    tag_t   tag1_rd;
    tag_t   tag_wd;
    line_t  data0_rd;
    line_t  data1_rd;
    line_t  line_wd;
    logic   valid0;
    logic   valid1;
    logic   dirty0;
    logic   dirty1;
    logic   dirty_wd;
    logic   lru;
    logic   lru_we;
    logic   lru_wd;
    logic   block0_we;
    logic   block1_we;

    assign fwd_data = out;                      // result before the pipeline reg

    mem_ctrl mem_ctrl_inst (
        .ex_en          (ex_en),
        .ex_mem_op      (ex_mem_op),
        .ex_mem_wr_data (ex_mem_wr_data),
        .ex_out         (ex_out),
        .read_data_m    (read_data_m),
        .addr           (addr),
        .access_mem     (access_mem),
        .memwrite_m     (memwrite_m),
        .wr_data        (wr_data),
        .out            (out),
        .miss_align     (miss_align)
    );

    dcache_ctrl dcache_ctrl_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .addr        (addr),
        .access_mem  (access_mem),
        .memwrite_m  (memwrite_m),
        .wr_data     (wr_data),
        .read_data_m (read_data_m),
        .miss_stall  (miss_stall),
        .index       (index),
        .tag0_rd     (tag0_rd),
        .tag1_rd     (tag1_rd),
        .valid0      (valid0),
        .valid1      (valid1),
        .dirty0      (dirty0),
        .dirty1      (dirty1),
        .lru         (lru),
        .data0_rd    (data0_rd),
        .data1_rd    (data1_rd),
        .block0_we   (block0_we),
        .block1_we   (block1_we),
        .tag_wd      (tag_wd),
        .line_wd     (line_wd),
        .dirty_wd    (dirty_wd),
        .lru_we      (lru_we),
        .lru_wd      (lru_wd),
        .drq         (drq),
        .l2_cache_rw (l2_cache_rw),
        .l2_addr     (l2_addr),
        .rd_to_l2    (rd_to_l2),
        .l2_rdy      (l2_rdy),
        .data_wd_l2  (data_wd_l2)
    );

    l1_dcache_ram l1_dcache_ram_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .index     (index),
        .block0_we (block0_we),
        .block1_we (block1_we),
        .tag_wd    (tag_wd),
        .line_wd   (line_wd),
        .dirty_wd  (dirty_wd),
        .lru_we    (lru_we),
        .lru_wd    (lru_wd),
        .tag0_rd   (tag0_rd),
        .tag1_rd   (tag1_rd),
        .valid0    (valid0),
        .valid1    (valid1),
        .dirty0    (dirty0),
        .dirty1    (dirty1),
        .lru       (lru),
        .data0_rd  (data0_rd),
        .data1_rd  (data1_rd)
    );

    mem_reg mem_reg_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .stall        (stall),
        .flush        (flush),
        .miss_stall   (miss_stall),
        .ex_en        (ex_en),
        .ex_dst_addr  (ex_dst_addr),
        .ex_gpr_we_n  (ex_gpr_we_n),
        .out          (out),
        .miss_align   (miss_align),
        .mem_en       (mem_en),
        .mem_dst_addr (mem_dst_addr),
        .mem_gpr_we_n (mem_gpr_we_n),
        .mem_out      (mem_out),
        .mem_misalign (mem_misalign)
    );

endmodule

/* test/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_PERIOD = 5,           // 10 ns clock
    parameter int RST_CYCLES  = 5
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;                     // release off the edge
    end

endmodule

/* test/tb_mem_stage.sv */
`timescale 1ns/1ps
`include "mem_stage_defs.svh"

module tb_mem_stage;
    import mem_pkg::*;

    localparam int NUM_OPS = 40;              // upper bound on ops issued below

    logic      clk;
    logic      arst_n;
    logic      stall;
    logic      flush;
    logic      ex_en;
    mem_op_t   ex_mem_op;
    word_t     ex_mem_wr_data;
    reg_addr_t ex_dst_addr;
    logic      ex_gpr_we_n;
    word_t     ex_out;
    word_t     fwd_data;
    logic      miss_stall;
    logic      drq;
    logic      l2_cache_rw;
    l2_addr_t  l2_addr;
    line_t     rd_to_l2;
    logic      l2_rdy;
    line_t     data_wd_l2;
    logic      mem_en;
    reg_addr_t mem_dst_addr;
    logic      mem_gpr_we_n;
    word_t     mem_out;
    logic      mem_misalign;

    line_t     l2_mem [l2_addr_t];            // sparse L2 lines, written back only
    word_t     shadow [word_t];               // stored words by word address
    logic [31:0] rng = 32'h2bee;
    int        errors;
    int        checks;
    int        tests;
    int        rd_reqs;
    int        wb_reqs;
    l2_addr_t  last_wb_addr;
    reg_addr_t dst_cnt;

    tb_clk_gen clk_gen_inst (.clk(clk), .arst_n(arst_n));

    mem_stage mem_stage_inst (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // untouched words follow the L2 fill pattern
    function automatic word_t shadow_rd(input word_t a);
        word_t wa;
        wa = {a[31:2], 2'b00};
        if (shadow.exists(wa)) return shadow[wa];
        return wa ^ 32'h5a5a0000;
    endfunction

    function automatic line_t shadow_line(input l2_addr_t la);
        line_t l;
        for (int k = 0; k < 4; k++) l[k*32 +: 32] = shadow_rd({la, 4'b0} + 4 * k);
        return l;
    endfunction

    function automatic line_t l2_line(input l2_addr_t la);
        line_t l;
        if (l2_mem.exists(la)) return l2_mem[la];
        for (int k = 0; k < 4; k++) l[k*32 +: 32] = ({la, 4'b0} + 4 * k) ^ 32'h5a5a0000;
        return l;
    endfunction

    task automatic check(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("[ERROR] %0t ns: %s", $time, what);
        end
    endtask

    task automatic end_test(input string name, input int err_at_start);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - err_at_start);
    endtask

    // L2 model, answers each request after 1 to 4 cycles
    initial begin
        int delay;
        l2_rdy     = 1'b0;
        data_wd_l2 = '0;
        forever begin
            @(negedge clk);
            if (drq) begin
                rng   = xorshift(rng);
                delay = 1 + (rng % 4);
                repeat (delay) @(posedge clk);
                #1;
                if (l2_cache_rw) begin
                    wb_reqs++;
                    last_wb_addr = l2_addr;
                    check(rd_to_l2 === shadow_line(l2_addr),
                          $sformatf("writeback line %h wrong data", l2_addr));
                    l2_mem[l2_addr] = rd_to_l2;
                end else begin
                    rd_reqs++;
                    data_wd_l2 = l2_line(l2_addr);
                end
                l2_rdy = 1'b1;
                @(posedge clk);
                #1 l2_rdy = 1'b0;
            end
        end
    end

    // request is held steady until ready
    a_drq_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (drq && !l2_rdy) |=> (drq && $stable(l2_addr) && $stable(l2_cache_rw)))
        else begin
            errors++;
            $display("[ERROR] %0t ns: drq dropped or changed before l2_rdy", $time);
        end

    a_misalign_no_we: assert property (@(posedge clk) disable iff (!arst_n)
        mem_misalign |-> mem_gpr_we_n)
        else begin
            errors++;
            $display("[ERROR] %0t ns: misaligned result would write a gpr", $time);
        end

    task automatic idle_inputs();
        ex_en          = 1'b0;
        ex_mem_op      = `MEM_OP_NOP;
        ex_mem_wr_data = '0;
        ex_gpr_we_n    = 1'b1;
        ex_out         = '0;
    endtask

    // one op, held until miss_stall is low, then result checked
    task automatic do_op(input mem_op_t op, input word_t a, input word_t wd,
                         input logic we_n, output logic missed, output logic drq_seen);
        word_t     w;
        word_t     exp;
        logic [7:0] b;
        logic      mis;
        logic      is_st;
        reg_addr_t dst;
        @(posedge clk);
        #1;
        mis   = ((op == `MEM_OP_LDW) || (op == `MEM_OP_STW)) && (a[1:0] != 2'b00);
        is_st = (op == `MEM_OP_STW) || (op == `MEM_OP_STB);
        w     = shadow_rd(a);
        b     = w[a[1:0]*8 +: 8];
        case (op)
            `MEM_OP_LDW:  exp = mis ? a : w;
            `MEM_OP_LDB:  exp = {{24{b[7]}}, b};
            `MEM_OP_LDBU: exp = {24'h0, b};
            default:      exp = a;
        endcase
        if (is_st && !mis) begin
            if (op == `MEM_OP_STW) w = wd;
            else w[a[1:0]*8 +: 8] = wd[7:0];
            shadow[{a[31:2], 2'b00}] = w;
        end
        dst            = dst_cnt;
        dst_cnt        = dst_cnt + 1;
        ex_en          = 1'b1;
        ex_mem_op      = op;
        ex_mem_wr_data = wd;
        ex_dst_addr    = dst;
        ex_gpr_we_n    = we_n;
        ex_out         = a;
        missed         = 1'b0;
        drq_seen       = 1'b0;
        @(negedge clk);
        if (op == `MEM_OP_NOP) check(fwd_data === a, "fwd_data differs from ex_out on nop");
        while (miss_stall) begin
            missed = 1'b1;
            if (drq) drq_seen = 1'b1;
            @(negedge clk);
        end
        if (drq) drq_seen = 1'b1;             // no request may outlive the stall
        @(posedge clk);
        #1 idle_inputs();
        @(negedge clk);
        check(mem_en === 1'b1, "mem_en low after op");
        check(mem_dst_addr === dst, "mem_dst_addr wrong");
        check(mem_misalign === mis, $sformatf("mem_misalign %b at %h", mem_misalign, a));
        check(mem_gpr_we_n === (mis ? 1'b1 : we_n), "mem_gpr_we_n not as supplied");
        if (!is_st) begin
            check(mem_out === exp,
                  $sformatf("op %h at %h gave %h, expected %h", op, a, mem_out, exp));
        end
    endtask

    initial begin
        int    e0;
        logic  m;
        logic  d;
        int    rd0;
        int    wb0;
        word_t held_out;
        logic  held_we_n;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        rd_reqs = 0;
        wb_reqs = 0;
        dst_cnt = '0;
        stall   = 1'b0;
        flush   = 1'b0;
        ex_dst_addr = '0;
        idle_inputs();

        e0 = errors;
        @(negedge clk);
        check(!miss_stall && !drq && !mem_en, "outputs active during reset");
        wait (arst_n);
        @(negedge clk);
        check(!miss_stall && !drq && !mem_en, "outputs active after reset");

        rd0 = rd_reqs;
        do_op(`MEM_OP_LDW, 32'h0000_0200, '0, 1'b0, m, d);
        check(m && d && (rd_reqs == rd0 + 1) && (wb_reqs == 0), "cold load did not refill");
        do_op(`MEM_OP_LDW, 32'h0000_0208, '0, 1'b0, m, d);
        check(!m, "second load in line missed");
        end_test("reset, cold load and hit", e0);

        e0 = errors;
        for (int k = 0; k < 4; k++) begin
            do_op(`MEM_OP_LDB, 32'h0000_8080 + k, '0, 1'b0, m, d);
            do_op(`MEM_OP_LDBU, 32'h0000_8080 + k, '0, 1'b0, m, d);
        end
        end_test("byte loads", e0);

        e0 = errors;
        do_op(`MEM_OP_STW, 32'h0000_0204, 32'h80ff_7f01, 1'b1, m, d);
        do_op(`MEM_OP_STB, 32'h0000_0205, 32'h0000_00a5, 1'b0, m, d);
        do_op(`MEM_OP_STB, 32'h0000_0300, 32'h0000_0011, 1'b1, m, d);
        do_op(`MEM_OP_LDW, 32'h0000_0204, '0, 1'b0, m, d);
        do_op(`MEM_OP_LDB, 32'h0000_0207, '0, 1'b0, m, d);
        do_op(`MEM_OP_LDW, 32'h0000_0300, '0, 1'b0, m, d);
        end_test("stores then loads", e0);

        e0 = errors;
        wb0 = wb_reqs;
        do_op(`MEM_OP_STW, 32'h0000_1040, 32'hcafe_0001, 1'b1, m, d);
        do_op(`MEM_OP_STW, 32'h0000_2044, 32'hcafe_0002, 1'b1, m, d);
        do_op(`MEM_OP_LDW, 32'h0000_3048, '0, 1'b0, m, d);
        check(wb_reqs == wb0 + 1, "dirty victim not written back");
        check(last_wb_addr == 28'h000_0104, "wrong line written back");
        do_op(`MEM_OP_LDW, 32'h0000_1040, '0, 1'b0, m, d);
        check(m, "evicted line still hit");
        do_op(`MEM_OP_LDW, 32'h0000_2044, '0, 1'b0, m, d);
        end_test("eviction", e0);

        e0 = errors;
        do_op(`MEM_OP_LDW, 32'h0000_4402, '0, 1'b0, m, d);
        check(!m && !d, "misaligned load reached L2");
        do_op(`MEM_OP_NOP, 32'h1234_abcd, '0, 1'b0, m, d);
        end_test("misaligned and nop", e0);

        e0 = errors;
        do_op(`MEM_OP_LDW, 32'h0000_0204, '0, 1'b0, m, d);
        @(posedge clk);
        #1;
        ex_en       = 1'b1;                   // line is warm, so this load hits
        ex_mem_op   = `MEM_OP_LDW;
        ex_out      = 32'h0000_0204;
        ex_gpr_we_n = 1'b0;
        ex_dst_addr = 5'd30;
        @(negedge clk);
        check(!miss_stall, "warm load before stall missed");
        @(posedge clk);
        #1;
        stall       = 1'b1;
        ex_out      = 32'h0000_0208;
        ex_dst_addr = 5'd31;
        @(negedge clk);
        held_out  = mem_out;
        held_we_n = mem_gpr_we_n;
        check(mem_en && (held_out === shadow_rd(32'h0000_0204)) && (held_we_n === 1'b0)
              && (mem_dst_addr === 5'd30), "load before stall gave a wrong result");
        repeat (3) begin
            @(negedge clk);
            check(mem_en && (mem_out === held_out) && (mem_gpr_we_n === held_we_n)
                  && (mem_dst_addr === 5'd30), "stall did not hold MEM/WB");
        end
        @(posedge clk);
        #1;
        stall = 1'b0;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        idle_inputs();
        @(negedge clk);
        check(!mem_en, "flush did not clear mem_en");
        end_test("stall and flush", e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog sized from the op count
    initial begin
        #(NUM_OPS * 40 * 10);
        $display("timeout, the run did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* mem_stage.f */
+incdir+include
verilog/mem_pkg.sv
verilog/mem_ctrl.sv
verilog/dcache_ctrl.sv
verilog/l1_dcache_ram.sv
verilog/mem_reg.sv
verilog/mem_stage.sv
test/tb_clk_gen.sv
test/tb_mem_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FLIST     ?= mem_stage.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || (echo "no result in log"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
